/* Makefile */
TOP = backend_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* source/backend_top.sv */
// ********************
// Back end top level. Joins the dispatcher, the execution lanes
// and the re-order buffer. Micro-ops enter and retire here.
// ********************
`timescale 1ns/1ps

module backend_top (
  input  logic                                                       clock,
  input  logic                                                       reset,
  input  logic                                                       in_valid,
  input  rob_pkg::uop_kind_e                                         in_kind,
  input  logic [rob_pkg::TAG_BITS-1:0]                               in_tag,
  input  rob_pkg::uop_payload_u                                      in_payload,
  output logic                                                       in_ready,
  output logic [rob_pkg::RETIRE_WIDTH-1:0]                           retire_valid,
  output logic [rob_pkg::RETIRE_WIDTH-1:0][rob_pkg::TAG_BITS-1:0]    retire_tag,
  output logic [rob_pkg::RETIRE_WIDTH-1:0][rob_pkg::RESULT_BITS-1:0] retire_result,
  output logic [rob_pkg::RETIRE_WIDTH-1:0]                           retire_taken,
  output logic                                                       recover,
  output logic [rob_pkg::TAG_BITS-1:0]                               recover_tag
);

  // Allocation path
  logic                                                       alloc_ok;
  logic [rob_pkg::ROB_INDEX_BITS-1:0]                         alloc_index;
  logic                                                       alloc_valid;
  rob_pkg::uop_kind_e                                         alloc_kind;
  logic [rob_pkg::TAG_BITS-1:0]                               alloc_tag;
  rob_pkg::uop_payload_u                                      alloc_payload;

  // Issue and credit path
  logic [rob_pkg::NUM_LANES-1:0]                              issue_valid;
  logic [rob_pkg::ROB_INDEX_BITS-1:0]                         issue_index;
  rob_pkg::uop_kind_e                                         issue_kind;
  rob_pkg::uop_payload_u                                      issue_payload;
  logic [rob_pkg::NUM_LANES-1:0]                              credit_return;

  // Completion path
  logic [rob_pkg::NUM_LANES-1:0]                              done_valid;
  logic [rob_pkg::NUM_LANES-1:0][rob_pkg::ROB_INDEX_BITS-1:0] done_index;
  logic [rob_pkg::NUM_LANES-1:0][rob_pkg::RESULT_BITS-1:0]    done_result;
  logic [rob_pkg::NUM_LANES-1:0]                              done_taken;

  uop_dispatch u_dispatch (
    .clock,
    .reset,
    .in_valid,
    .in_kind,
    .in_tag,
    .in_payload,
    .in_ready,
    .alloc_ok,
    .alloc_index,
    .alloc_valid,
    .alloc_kind,
    .alloc_tag,
    .alloc_payload,
    .issue_valid,
    .issue_index,
    .issue_kind,
    .issue_payload,
    .credit_return,
    .recover
  );

  // Lanes share the issue bus and see recover as flush
  for (genvar g = 0; g < rob_pkg::NUM_LANES; g++) begin : g_lane
    exec_lane u_lane (
      .clock,
      .reset,
      .flush         (recover),
      .issue_valid   (issue_valid[g]),
      .issue_index,
      .issue_kind,
      .issue_payload,
      .credit_return (credit_return[g]),
      .done_valid    (done_valid[g]),
      .done_index    (done_index[g]),
      .done_result   (done_result[g]),
      .done_taken    (done_taken[g])
    );
  end

  rob u_rob (
    .clock,
    .reset,
    .alloc_valid,
    .alloc_kind,
    .alloc_tag,
    .alloc_payload,
    .alloc_ok,
    .alloc_index,
    .done_valid,
    .done_index,
    .done_result,
    .done_taken,
    .retire_valid,
    .retire_tag,
    .retire_result,
    .retire_taken,
    .recover,
    .recover_tag
  );

endmodule

/* source/exec_lane.sv */
// ********************
// One execution lane. Queues issued micro-ops, runs them through a
// single variable-latency stage, returns credits and reports completion.
// ********************
`timescale 1ns/1ps

module exec_lane (
  input  logic                                clock,
  input  logic                                reset,
  input  logic                                flush,
  input  logic                                issue_valid,
  input  logic [rob_pkg::ROB_INDEX_BITS-1:0]  issue_index,
  input  rob_pkg::uop_kind_e                  issue_kind,
  input  rob_pkg::uop_payload_u               issue_payload,
  output logic                                credit_return,
  output logic                                done_valid,
  output logic [rob_pkg::ROB_INDEX_BITS-1:0]  done_index,
  output logic [rob_pkg::RESULT_BITS-1:0]     done_result,
  output logic                                done_taken
);

  logic [rob_pkg::ROB_INDEX_BITS-1:0] q_index   [rob_pkg::LANE_DEPTH];
  rob_pkg::uop_kind_e                 q_kind    [rob_pkg::LANE_DEPTH];
  rob_pkg::uop_payload_u              q_payload [rob_pkg::LANE_DEPTH];
  logic [rob_pkg::LANE_PTR_BITS-1:0]  rd_ptr;
  logic [rob_pkg::LANE_PTR_BITS-1:0]  wr_ptr;
  logic [rob_pkg::CREDIT_BITS-1:0]    q_count;

  logic                               busy;
  logic [rob_pkg::CYCLE_BITS-1:0]     cycles_left;
  logic                               stage_free;
  logic                               take;
  logic                               push;
  logic                               pop;

  logic [rob_pkg::ROB_INDEX_BITS-1:0] sel_index;
  rob_pkg::uop_kind_e                 sel_kind;
  rob_pkg::uop_payload_u              sel_payload;
  logic [rob_pkg::RESULT_BITS-1:0]    sel_result;
  logic                               sel_taken;
  logic [rob_pkg::CYCLE_BITS-1:0]     sel_cycles;
  logic [2*rob_pkg::OPERAND_BITS-1:0] product;

  // Stage takes new work only once it is idle
  assign stage_free    = !busy;
  assign pop           = stage_free && q_count != '0;
  // An empty queue passes a new issue straight to the stage
  assign take          = stage_free && (q_count != '0 || issue_valid);
  assign push          = issue_valid && !(take && q_count == '0);
  assign credit_return = take;

  always_comb begin
    if (q_count != '0) begin
      sel_index   = q_index[rd_ptr];
      sel_kind    = q_kind[rd_ptr];
      sel_payload = q_payload[rd_ptr];
    end else begin
      sel_index   = issue_index;
      sel_kind    = issue_kind;
      sel_payload = issue_payload;
    end
  end

  assign product = sel_payload.alu.a * sel_payload.alu.b;

  always_comb begin
    sel_result = '0;
    sel_taken  = 1'b0;
    sel_cycles = '0;
    if (sel_kind == rob_pkg::UOP_BRANCH) begin
      sel_taken = (sel_payload.br.a == sel_payload.br.b) ^ sel_payload.br.not_equal;
    end else begin
      case (sel_payload.alu.op)
        rob_pkg::ALU_ADD: sel_result = {1'b0, sel_payload.alu.a} + {1'b0, sel_payload.alu.b};
        rob_pkg::ALU_XOR: sel_result = {1'b0, sel_payload.alu.a ^ sel_payload.alu.b};
        rob_pkg::ALU_AND: sel_result = {1'b0, sel_payload.alu.a & sel_payload.alu.b};
        default: begin
          sel_result = product[rob_pkg::RESULT_BITS-1:0];
          sel_cycles = rob_pkg::MUL_WAIT;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr  <= '0;
      wr_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      q_count <= q_count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clock) begin
    if (push) begin
      q_index[wr_ptr]   <= issue_index;
      q_kind[wr_ptr]    <= issue_kind;
      q_payload[wr_ptr] <= issue_payload;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      busy        <= 1'b0;
      cycles_left <= '0;
    end else if (take) begin
      busy        <= 1'b1;
      cycles_left <= sel_cycles;
    end else if (cycles_left == '0) begin
      busy <= 1'b0;
    end else begin
      cycles_left <= cycles_left - 1'b1;
    end
  end

  // Result is formed at load and held until the countdown ends
  always_ff @(posedge clock) begin
    if (take) begin
      done_index  <= sel_index;
      done_result <= sel_result;
      done_taken  <= sel_taken;
    end
  end

  assign done_valid = busy && cycles_left == '0;

  a_no_overflow: assert property (@(posedge clock) disable iff (reset || flush)
    issue_valid |-> q_count < rob_pkg::LANE_DEPTH);

endmodule

/* source/rob.sv */
// ********************
// Re-order buffer. Allocates at the tail, marks lane completions,
// retires up to two entries per cycle from the head in program order
// and raises recover on a mispredicted branch.
// ********************
`timescale 1ns/1ps

module rob (
  input  logic                                                      clock,
  input  logic                                                      reset,
  input  logic                                                      alloc_valid,
  input  rob_pkg::uop_kind_e                                        alloc_kind,
  input  logic [rob_pkg::TAG_BITS-1:0]                              alloc_tag,
  input  rob_pkg::uop_payload_u                                     alloc_payload,
  output logic                                                      alloc_ok,
  output logic [rob_pkg::ROB_INDEX_BITS-1:0]                        alloc_index,
  input  logic [rob_pkg::NUM_LANES-1:0]                             done_valid,
  input  logic [rob_pkg::NUM_LANES-1:0][rob_pkg::ROB_INDEX_BITS-1:0] done_index,
  input  logic [rob_pkg::NUM_LANES-1:0][rob_pkg::RESULT_BITS-1:0]   done_result,
  input  logic [rob_pkg::NUM_LANES-1:0]                             done_taken,
  output logic [rob_pkg::RETIRE_WIDTH-1:0]                          retire_valid,
  output logic [rob_pkg::RETIRE_WIDTH-1:0][rob_pkg::TAG_BITS-1:0]   retire_tag,
  output logic [rob_pkg::RETIRE_WIDTH-1:0][rob_pkg::RESULT_BITS-1:0] retire_result,
  output logic [rob_pkg::RETIRE_WIDTH-1:0]                          retire_taken,
  output logic                                                      recover,
  output logic [rob_pkg::TAG_BITS-1:0]                              recover_tag
);

  rob_pkg::uop_kind_e              e_kind   [rob_pkg::ROB_SIZE];
  logic [rob_pkg::TAG_BITS-1:0]    e_tag    [rob_pkg::ROB_SIZE];
  logic                            e_pred   [rob_pkg::ROB_SIZE];
  logic [rob_pkg::RESULT_BITS-1:0] e_result [rob_pkg::ROB_SIZE];
  logic                            e_taken  [rob_pkg::ROB_SIZE];
  logic [rob_pkg::ROB_SIZE-1:0]    e_done;

  logic [rob_pkg::ROB_INDEX_BITS-1:0] head;
  logic [rob_pkg::ROB_INDEX_BITS:0]   count;
  logic [rob_pkg::ROB_INDEX_BITS:0]   retire_count;
  logic [rob_pkg::ROB_INDEX_BITS-1:0] slot;
  logic                               stop;

  // Count top bit set means all slots taken
  assign alloc_ok    = !count[rob_pkg::ROB_INDEX_BITS];
  assign alloc_index = head + count[rob_pkg::ROB_INDEX_BITS-1:0];

  // Walk from the head until an incomplete entry or a mispredict
  always_comb begin
    retire_valid  = '0;
    retire_tag    = '0;
    retire_result = '0;
    retire_taken  = '0;
    retire_count  = '0;
    recover       = 1'b0;
    recover_tag   = '0;
    stop          = 1'b0;
    slot          = head;
    for (int i = 0; i < rob_pkg::RETIRE_WIDTH; i++) begin
      slot = head + i[rob_pkg::ROB_INDEX_BITS-1:0];
      if (!stop && count > i[rob_pkg::ROB_INDEX_BITS:0] && e_done[slot]) begin
        retire_valid[i]  = 1'b1;
        retire_tag[i]    = e_tag[slot];
        retire_result[i] = e_result[slot];
        retire_taken[i]  = e_taken[slot];
        retire_count     = retire_count + 1'b1;
        if (e_kind[slot] == rob_pkg::UOP_BRANCH && e_taken[slot] != e_pred[slot]) begin
          recover     = 1'b1;
          recover_tag = e_tag[slot];
          stop        = 1'b1;
        end
      end else begin
        stop = 1'b1;
      end
    end
  end

  // Recovery empties the whole buffer at the next edge
  always_ff @(posedge clock) begin
    if (reset || recover) begin
      head   <= '0;
      count  <= '0;
      e_done <= '0;
    end else begin
      head  <= head + retire_count[rob_pkg::ROB_INDEX_BITS-1:0];
      count <= count + {{rob_pkg::ROB_INDEX_BITS{1'b0}}, alloc_valid} - retire_count;
      for (int l = 0; l < rob_pkg::NUM_LANES; l++) begin
        if (done_valid[l]) begin
          e_done[done_index[l]] <= 1'b1;
        end
      end
      if (alloc_valid) begin
        e_done[alloc_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc_valid) begin
      e_kind[alloc_index] <= alloc_kind;
      e_tag[alloc_index]  <= alloc_tag;
      // Only meaningful for branches
      e_pred[alloc_index] <= alloc_payload.br.pred_taken;
    end
    for (int l = 0; l < rob_pkg::NUM_LANES; l++) begin
      if (done_valid[l]) begin
        e_result[done_index[l]] <= done_result[l];
        e_taken[done_index[l]]  <= done_taken[l];
      end
    end
  end

  for (genvar g = 0; g < rob_pkg::NUM_LANES; g++) begin : g_done_check
    a_done_live: assert property (@(posedge clock) disable iff (reset)
      done_valid[g] |-> rob_pkg::ROB_INDEX_BITS'(done_index[g] - head) < count);
  end

  a_occupancy: assert property (@(posedge clock) disable iff (reset)
    count <= rob_pkg::ROB_SIZE);

endmodule

/* source/rob_pkg.sv */
// ********************
// Sizes, micro-op encodings and the payload union shared by the
// re-order buffer back end. Users refer to items by scoped name.
// ********************

package rob_pkg;

  // Lanes and their queues
  localparam int NUM_LANES     = 3;
  localparam int LANE_BITS     = 2;
  localparam int LANE_DEPTH    = 2;
  localparam int LANE_PTR_BITS = 1;
  localparam int CREDIT_BITS   = 2;

  // Re-order buffer geometry
  localparam int ROB_SIZE       = 8;
  localparam int ROB_INDEX_BITS = 3;
  localparam int RETIRE_WIDTH   = 2;

  // Field widths
  localparam int TAG_BITS     = 8;
  localparam int RESULT_BITS  = 8;
  localparam int OPERAND_BITS = 7;

  // Multiply latency, counted down in the lane stage
  localparam int MUL_CYCLES = 3;
  localparam int CYCLE_BITS = 2;
  localparam logic [CYCLE_BITS-1:0] MUL_WAIT = CYCLE_BITS'(MUL_CYCLES - 1);

  // Reload value of a lane credit counter
  localparam logic [CREDIT_BITS-1:0] FULL_CREDIT = CREDIT_BITS'(LANE_DEPTH);

  typedef enum logic {
    UOP_ALU    = 1'b0,
    UOP_BRANCH = 1'b1
  } uop_kind_e;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_XOR = 2'd1,
    ALU_AND = 2'd2,
    ALU_MUL = 2'd3
  } alu_op_e;

  // Payload seen as an ALU operation
  typedef struct packed {
    alu_op_e                 op;
    logic [OPERAND_BITS-1:0] a;
    logic [OPERAND_BITS-1:0] b;
  } alu_view_t;

  // Same word seen as a branch compare
  typedef struct packed {
    logic                    pred_taken;
    logic                    not_equal;
    logic [OPERAND_BITS-1:0] a;
    logic [OPERAND_BITS-1:0] b;
  } branch_view_t;

  typedef union packed {
    alu_view_t    alu;
    branch_view_t br;
  } uop_payload_u;

endpackage

/* source/uop_dispatch.sv */
// ********************
// Accepts micro-ops, allocates the re-order buffer tail and issues
// each one to a lane chosen round-robin among lanes holding a credit.
// ********************
`timescale 1ns/1ps

module uop_dispatch (
  input  logic                                 clock,
  input  logic                                 reset,
  input  logic                                 in_valid,
  input  rob_pkg::uop_kind_e                   in_kind,
  input  logic [rob_pkg::TAG_BITS-1:0]         in_tag,
  input  rob_pkg::uop_payload_u                in_payload,
  output logic                                 in_ready,
  input  logic                                 alloc_ok,
  input  logic [rob_pkg::ROB_INDEX_BITS-1:0]   alloc_index,
  output logic                                 alloc_valid,
  output rob_pkg::uop_kind_e                   alloc_kind,
  output logic [rob_pkg::TAG_BITS-1:0]         alloc_tag,
  output rob_pkg::uop_payload_u                alloc_payload,
  output logic [rob_pkg::NUM_LANES-1:0]        issue_valid,
  output logic [rob_pkg::ROB_INDEX_BITS-1:0]   issue_index,
  output rob_pkg::uop_kind_e                   issue_kind,
  output rob_pkg::uop_payload_u                issue_payload,
  input  logic [rob_pkg::NUM_LANES-1:0]        credit_return,
  input  logic                                 recover
);

  logic [rob_pkg::CREDIT_BITS-1:0] credit [rob_pkg::NUM_LANES];
  logic [rob_pkg::NUM_LANES-1:0]   has_credit;
  logic [rob_pkg::NUM_LANES-1:0]   grant;
  logic [rob_pkg::LANE_BITS-1:0]   last_lane;
  logic [rob_pkg::LANE_BITS-1:0]   pick;
  logic                            found;
  logic                            accept;
  int                              cand;

  // Search starts one past the lane used last
  always_comb begin
    pick  = last_lane;
    found = 1'b0;
    cand  = 0;
    for (int k = 1; k <= rob_pkg::NUM_LANES; k++) begin
      cand = (int'(last_lane) + k) % rob_pkg::NUM_LANES;
      if (!found && has_credit[cand]) begin
        pick  = cand[rob_pkg::LANE_BITS-1:0];
        found = 1'b1;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < rob_pkg::NUM_LANES; i++) begin
      has_credit[i] = credit[i] != '0;
      grant[i]      = accept && (pick == i[rob_pkg::LANE_BITS-1:0]);
    end
  end

  assign in_ready = alloc_ok && (|has_credit) && !recover;
  assign accept   = in_valid && in_ready;

  // ROB write happens on the acceptance edge
  assign alloc_valid   = accept;
  assign alloc_kind    = in_kind;
  assign alloc_tag     = in_tag;
  assign alloc_payload = in_payload;

  always_ff @(posedge clock) begin
    if (reset) begin
      issue_valid <= '0;
      last_lane   <= '0;
    end else begin
      issue_valid <= grant;
      if (accept) begin
        last_lane <= pick;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      issue_index   <= alloc_index;
      issue_kind    <= in_kind;
      issue_payload <= in_payload;
    end
  end

  // One credit per free lane queue slot
  always_ff @(posedge clock) begin
    for (int i = 0; i < rob_pkg::NUM_LANES; i++) begin
      if (reset || recover) begin
        credit[i] <= rob_pkg::FULL_CREDIT;
      end else if (grant[i] && !credit_return[i]) begin
        credit[i] <= credit[i] - 1'b1;
      end else if (credit_return[i] && !grant[i]) begin
        credit[i] <= credit[i] + 1'b1;
      end
    end
  end

  for (genvar g = 0; g < rob_pkg::NUM_LANES; g++) begin : g_credit_check
    a_credit_max: assert property (@(posedge clock) disable iff (reset)
      credit[g] <= rob_pkg::LANE_DEPTH);
    a_grant_credit: assert property (@(posedge clock) disable iff (reset)
      grant[g] |-> credit[g] != '0);
  end

endmodule

/* src.f */
source/rob_pkg.sv
source/uop_dispatch.sv
source/exec_lane.sv
source/rob.sv
source/backend_top.sv
tests/backend_tb.sv

/* tests/backend_tb.sv */
// ********************
// Testbench for the back end. Streams random micro-ops into the top level,
// predicts each retirement with a reference model and checks order,
// results, recovery and stall behavior.
// ********************
`timescale 1ns/1ps

module backend_tb;

  localparam int ALU_COUNT      = 60;
  localparam int MIXED_COUNT    = 30;
  localparam int RECOVER_COUNT  = 21;
  localparam int STREAM_COUNT   = 24;
  localparam int TOTAL_UOPS     = ALU_COUNT + MIXED_COUNT + RECOVER_COUNT + STREAM_COUNT;
  localparam int TIMEOUT_CYCLES = TOTAL_UOPS * 20 + 200;

  typedef struct packed {
    logic [rob_pkg::TAG_BITS-1:0]    tag;
    logic [rob_pkg::RESULT_BITS-1:0] result;
    logic                            taken;
    logic                            mispredict;
  } expect_t;

  logic                                                       clock = 1'b0;
  logic                                                       reset;
  logic                                                       in_valid;
  rob_pkg::uop_kind_e                                         in_kind;
  logic [rob_pkg::TAG_BITS-1:0]                               in_tag;
  rob_pkg::uop_payload_u                                      in_payload;
  logic                                                       in_ready;
  logic [rob_pkg::RETIRE_WIDTH-1:0]                           retire_valid;
  logic [rob_pkg::RETIRE_WIDTH-1:0][rob_pkg::TAG_BITS-1:0]    retire_tag;
  logic [rob_pkg::RETIRE_WIDTH-1:0][rob_pkg::RESULT_BITS-1:0] retire_result;
  logic [rob_pkg::RETIRE_WIDTH-1:0]                           retire_taken;
  logic                                                       recover;
  logic [rob_pkg::TAG_BITS-1:0]                               recover_tag;

  // Accepted micro-ops not yet retired, oldest first
  expect_t                      exp_q[$];
  logic [31:0]                  lfsr     = 32'he7fb_6475;
  logic [rob_pkg::TAG_BITS-1:0] next_tag = '0;
  int errors          = 0;
  int errors_at_start = 0;
  int tests_passed    = 0;
  int tests_failed    = 0;
  int accepted        = 0;
  int retired         = 0;
  int recovers        = 0;
  int flushed         = 0;
  int stalls          = 0;

  always #5 clock = ~clock;

  backend_top u_backend_top (
    .clock,
    .reset,
    .in_valid,
    .in_kind,
    .in_tag,
    .in_payload,
    .in_ready,
    .retire_valid,
    .retire_tag,
    .retire_result,
    .retire_taken,
    .recover,
    .recover_tag
  );

  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr  = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      value = {value[30:0], lfsr[0]};
    end
    return value;
  endfunction

  // Expected {taken, result} worked out from the payload rules
  function automatic logic [8:0] expected_outcome(input rob_pkg::uop_kind_e kind,
                                                  input rob_pkg::uop_payload_u p);
    int   a;
    int   b;
    int   value;
    logic taken;
    value = 0;
    taken = 1'b0;
    if (kind == rob_pkg::UOP_BRANCH) begin
      a = int'(p.br.a);
      b = int'(p.br.b);
      taken = p.br.not_equal ? (a != b) : (a == b);
    end else begin
      a = int'(p.alu.a);
      b = int'(p.alu.b);
      case (p.alu.op)
        rob_pkg::ALU_ADD: value = a + b;
        rob_pkg::ALU_XOR: value = a ^ b;
        rob_pkg::ALU_AND: value = a & b;
        default:          value = a * b;
      endcase
    end
    return {taken, 8'(value % 256)};
  endfunction

  function automatic rob_pkg::uop_payload_u random_alu();
    rob_pkg::uop_payload_u p;
    p.alu.op = rob_pkg::alu_op_e'(2'(random_bits(2)));
    p.alu.a  = 7'(random_bits(7));
    p.alu.b  = 7'(random_bits(7));
    return p;
  endfunction

  function automatic rob_pkg::uop_payload_u random_mul();
    rob_pkg::uop_payload_u p;
    p        = random_alu();
    p.alu.op = rob_pkg::ALU_MUL;
    return p;
  endfunction

  // Half of the compares get equal operands
  function automatic rob_pkg::uop_payload_u random_branch(input logic wrong);
    rob_pkg::uop_payload_u p;
    logic [8:0]            outcome;
    p.br.pred_taken = 1'b0;
    p.br.not_equal  = random_bits(1) != 0;
    p.br.a          = 7'(random_bits(7));
    p.br.b          = random_bits(1) != 0 ? p.br.a : 7'(random_bits(7));
    outcome         = expected_outcome(rob_pkg::UOP_BRANCH, p);
    p.br.pred_taken = outcome[8] ^ wrong;
    return p;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("[ERROR] %0t ns: %s expected 0x%0h got 0x%0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic report_problem(input string text);
    $display("[ERROR] %0t ns: %s", $time, text);
    errors++;
  endtask

  // Holds the micro-op on the inputs until the DUT takes it
  task automatic drive_uop(input rob_pkg::uop_kind_e kind, input rob_pkg::uop_payload_u payload);
    @(negedge clock);
    in_valid   = 1'b1;
    in_kind    = kind;
    in_tag     = next_tag;
    in_payload = payload;
    @(posedge clock);
    while (in_ready !== 1'b1) begin
      @(posedge clock);
    end
    next_tag++;
  endtask

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(negedge clock);
      in_valid = 1'b0;
    end
  endtask

  task automatic wait_drain();
    @(negedge clock);
    in_valid = 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clock);
    end
    repeat (2) @(negedge clock);
  endtask

  task automatic finish_test(input int number, input string name);
    if (errors == errors_at_start) begin
      tests_passed++;
      $display("test %0d %s: passed", number, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", number, name, errors - errors_at_start);
    end
    errors_at_start = errors;
  endtask

  // Retirements are checked before this edge's acceptance is recorded
  always @(posedge clock) begin : monitor
    int         occupancy;
    logic       mispredict_seen;
    expect_t    entry;
    logic [8:0] outcome;
    if (!reset) begin
      occupancy       = exp_q.size();
      mispredict_seen = 1'b0;
      if (occupancy > rob_pkg::ROB_SIZE) begin
        report_problem($sformatf("%0d micro-ops outstanding, more than the buffer holds",
                                 occupancy));
      end
      // A stall needs a full buffer or every lane credit in use
      if (in_valid && !in_ready && !recover) begin
        stalls++;
        if (occupancy < rob_pkg::NUM_LANES * rob_pkg::LANE_DEPTH) begin
          report_problem($sformatf("in_ready low with only %0d micro-ops outstanding",
                                   occupancy));
        end
      end
      if (retire_valid[1] && !retire_valid[0]) begin
        report_problem("retire slot 1 valid while slot 0 is empty");
      end
      for (int s = 0; s < rob_pkg::RETIRE_WIDTH; s++) begin
        if (retire_valid[s]) begin
          if (mispredict_seen) begin
            report_problem("micro-op retired after a mispredicted branch in the same cycle");
          end else if (exp_q.size() == 0) begin
            report_problem("retirement with no micro-op outstanding");
          end else begin
            entry = exp_q.pop_front();
            retired++;
            if (retire_tag[s] !== entry.tag) begin
              report_mismatch($sformatf("retire_tag[%0d]", s), entry.tag, retire_tag[s]);
            end
            if (retire_result[s] !== entry.result) begin
              report_mismatch($sformatf("retire_result[%0d]", s), entry.result, retire_result[s]);
            end
            if (retire_taken[s] !== entry.taken) begin
              report_mismatch($sformatf("retire_taken[%0d]", s), entry.taken, retire_taken[s]);
            end
            if (entry.mispredict) begin
              mispredict_seen = 1'b1;
              if (recover !== 1'b1) begin
                report_mismatch("recover", 1, recover);
              end
              if (recover_tag !== entry.tag) begin
                report_mismatch("recover_tag", entry.tag, recover_tag);
              end
              // Everything younger is flushed
              flushed += exp_q.size();
              exp_q.delete();
            end
          end
        end
      end
      if (recover === 1'b1) begin
        recovers++;
        if (!mispredict_seen) begin
          report_problem("recover raised without a mispredicted branch retiring");
        end
      end
      if (in_valid && in_ready) begin
        outcome          = expected_outcome(in_kind, in_payload);
        entry.tag        = in_tag;
        entry.result     = outcome[7:0];
        entry.taken      = outcome[8];
        entry.mispredict = in_kind == rob_pkg::UOP_BRANCH &&
                           outcome[8] != in_payload.br.pred_taken;
        exp_q.push_back(entry);
        accepted++;
      end
    end
  end

  initial begin
    int start_recovers;
    int start_flushed;
    int start_stalls;
    reset      = 1'b1;
    in_valid   = 1'b0;
    in_kind    = rob_pkg::UOP_ALU;
    in_tag     = '0;
    in_payload = '0;

    repeat (8) begin
      @(negedge clock);
      if (retire_valid !== '0) begin
        report_problem("retire_valid high during reset");
      end
      if (recover !== 1'b0) begin
        report_problem("recover high during reset");
      end
    end
    reset = 1'b0;
    @(negedge clock);
    if (in_ready !== 1'b1) begin
      report_mismatch("in_ready", 1, in_ready);
    end
    if (retire_valid !== '0) begin
      report_mismatch("retire_valid", 0, retire_valid);
    end
    if (recover !== 1'b0) begin
      report_mismatch("recover", 0, recover);
    end
    finish_test(1, "reset behavior");

    for (int i = 0; i < ALU_COUNT; i++) begin
      drive_uop(rob_pkg::UOP_ALU, random_alu());
      if (random_bits(2) == 0) begin
        idle_cycles(1 + int'(random_bits(1)));
      end
    end
    wait_drain();
    finish_test(2, "ALU stream");

    start_recovers = recovers;
    for (int i = 0; i < MIXED_COUNT; i++) begin
      if (random_bits(1) != 0) begin
        drive_uop(rob_pkg::UOP_BRANCH, random_branch(1'b0));
      end else begin
        drive_uop(rob_pkg::UOP_ALU, random_alu());
      end
    end
    wait_drain();
    if (recovers != start_recovers) begin
      report_problem("recovery seen with only correctly predicted branches");
    end
    finish_test(3, "predicted branches");

    // Younger multiplies are still in flight when the branch retires
    start_recovers = recovers;
    start_flushed  = flushed;
    for (int i = 0; i < 4; i++) begin
      drive_uop(rob_pkg::UOP_ALU, random_alu());
    end
    drive_uop(rob_pkg::UOP_BRANCH, random_branch(1'b1));
    for (int i = 0; i < 6; i++) begin
      drive_uop(rob_pkg::UOP_ALU, random_mul());
    end
    for (int i = 0; i < 10; i++) begin
      drive_uop(rob_pkg::UOP_ALU, random_alu());
    end
    wait_drain();
    if (recovers != start_recovers + 1) begin
      report_problem("mispredicted branch did not cause exactly one recovery");
    end
    if (flushed == start_flushed) begin
      report_problem("no younger micro-op was outstanding at the recovery");
    end
    finish_test(4, "misprediction recovery");

    start_stalls = stalls;
    for (int i = 0; i < STREAM_COUNT; i++) begin
      drive_uop(rob_pkg::UOP_ALU, random_mul());
    end
    wait_drain();
    if (stalls == start_stalls) begin
      report_problem("in_ready never dropped during the multiply stream");
    end
    finish_test(5, "back-pressure");

    $display("tests passed %0d, failed %0d, errors %0d, accepted %0d, retired %0d",
             tests_passed, tests_failed, errors, accepted, retired);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("[ERROR] %0t ns: run did not finish within %0d cycles", $time, TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
